// File: ex_pkg.sv
/*
 * Shared types for the execution stage: data widths, ALU and multdiv
 * operation codes, RV32M options and multdiv FSM states
 */
`default_nettype none

package ex_pkg;

  // Data widths
  typedef logic [31:0] word_t;
  // Adder operand with the carry-in slot in bit 0
  typedef logic [32:0] adder_op_t;
  // Adder sum with carry out in bit 33
  typedef logic [33:0] adder_ext_t;
  typedef logic [33:0] imd_val_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    MD_OP_MUL,
    MD_OP_MULHU,
    MD_OP_DIVU,
    MD_OP_REMU
  } md_op_e;

  typedef enum logic {
    RV32MNone,
    RV32MSlow
  } rv32m_e;

  typedef enum logic [2:0] {
    MD_IDLE,
    MD_INIT,
    MD_RUN,
    MD_FIX,
    MD_DONE
  } md_state_e;

endpackage

`default_nettype wire

// File: ex_if.sv
/*
 * Shared adder bus between ALU and multdiv, and the
 * intermediate value register bus
 */
`default_nettype none

interface ex_adder_if import ex_pkg::*; ();
  adder_op_t  operand_a;
  adder_op_t  operand_b;
  word_t      adder_result;
  adder_ext_t adder_ext;
  logic       is_equal;

  modport md  (output operand_a, operand_b, input adder_result, adder_ext, is_equal);
  modport alu (input operand_a, operand_b, output adder_result, adder_ext, is_equal);
endinterface

interface ex_imd_if import ex_pkg::*; ();
  logic [1:0] we;
  imd_val_t   d0;
  imd_val_t   d1;
  imd_val_t   q0;
  imd_val_t   q1;

  modport ex   (output we, d0, d1, input q0, q1);
  modport regs (input we, d0, d1, output q0, q1);
endinterface

`default_nettype wire

// File: ex_alu.sv
/*
 * ALU: add/sub, logic, shifts, set-less-than and branch compares,
 * with the 33-bit adder shared out to the multdiv
 */
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  input  logic    multdiv_sel_i,
  ex_adder_if.alu adder,
  output word_t   result_o,
  output logic    comparison_o
);

  logic       adder_negate;
  adder_op_t  adder_in_a;
  adder_op_t  adder_in_b;
  adder_ext_t adder_sum;
  word_t      adder_result;
  logic       is_equal;
  logic       lt_signed;
  logic       lt_unsigned;
  logic [4:0] shamt;
  word_t      shift_result;

  ///////////////////////////////
  // Adder
  ///////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: adder_negate = 1'b1;
      default:                          adder_negate = 1'b0;
    endcase
  end

  // Subtract as a + ~b + 1 with the +1 entering through bit 0
  always_comb begin
    if (multdiv_sel_i) begin
      adder_in_a = adder.operand_a;
      adder_in_b = adder.operand_b;
    end else begin
      adder_in_a = {operand_a_i, 1'b1};
      adder_in_b = {operand_b_i, 1'b0} ^ {33{adder_negate}};
    end
  end

  assign adder_sum    = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result = adder_sum[32:1];
  assign is_equal     = ~|adder_result;

  assign adder.adder_result = adder_result;
  assign adder.adder_ext    = adder_sum;
  assign adder.is_equal     = is_equal;

  ///////////////////////////////
  // Compares
  ///////////////////////////////

  // No carry out means a borrow, so a < b
  assign lt_unsigned = ~adder_sum[33];
  // Differing signs decide directly, else the sign of the difference
  assign lt_signed   = (operand_a_i[31] ^ operand_b_i[31]) ? operand_a_i[31] : adder_result[31];

  always_comb begin
    case (operator_i)
      ALU_EQ:           comparison_o = is_equal;
      ALU_NE:           comparison_o = ~is_equal;
      ALU_LT, ALU_SLT:  comparison_o = lt_signed;
      ALU_GE:           comparison_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: comparison_o = lt_unsigned;
      ALU_GEU:          comparison_o = ~lt_unsigned;
      default:          comparison_o = 1'b0;
    endcase
  end

  ///////////////////////////////
  // Shifts and result mux
  ///////////////////////////////

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ALU_SLL: shift_result = operand_a_i << shamt;
      ALU_SRA: shift_result = $unsigned($signed(operand_a_i) >>> shamt);
      default: shift_result = operand_a_i >> shamt;
    endcase
  end

  always_comb begin
    case (operator_i)
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT, ALU_SLTU:         result_o = {31'b0, comparison_o};
      default:                   result_o = adder_result;
    endcase
  end

endmodule

`default_nettype wire

// File: ex_multdiv.sv
/*
 * Iterative multiply (shift-add) and unsigned restoring divide,
 * one bit per cycle on the ALU adder
 */
`default_nettype none

module ex_multdiv import ex_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   mult_en_i,
  input  logic   div_en_i,
  input  md_op_e operator_i,
  input  word_t  op_a_i,
  input  word_t  op_b_i,
  ex_adder_if.md adder,
  ex_imd_if.ex   imd,
  output logic   valid_o,
  output word_t  result_o
);

  md_state_e   state_q, state_d;
  logic [4:0]  count_q, count_d;
  logic        div_zero_q, div_zero_d;
  logic        md_en;
  word_t       acc;
  word_t       shreg;
  logic [32:0] rem_shift;
  logic        sub_ok;

  assign md_en = mult_en_i | div_en_i;

  // Register 0 holds partial product or remainder, register 1 multiplier or quotient
  assign acc   = imd.q0[31:0];
  assign shreg = imd.q1[31:0];

  // Next dividend bit shifted into the remainder
  assign rem_shift = {acc, shreg[31]};
  // Bit 32 set means the partial remainder already exceeds any divisor
  assign sub_ok    = rem_shift[32] | adder.adder_ext[33];

  // Bit 0 of each adder operand is the carry-in
  always_comb begin
    adder.operand_a = '0;
    adder.operand_b = '0;
    case (state_q)
      MD_INIT: adder.operand_a = {op_b_i, 1'b0};
      MD_RUN: begin
        if (div_en_i) begin
          adder.operand_a = {rem_shift[31:0], 1'b1};
          adder.operand_b = {~op_b_i, 1'b1};
        end else begin
          adder.operand_a = {acc, 1'b0};
          adder.operand_b = shreg[0] ? {op_a_i, 1'b0} : '0;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d    = state_q;
    count_d    = count_q;
    div_zero_d = div_zero_q;
    imd.we     = 2'b00;
    imd.d0     = '0;
    imd.d1     = '0;
    valid_o    = 1'b0;
    case (state_q)
      MD_IDLE: begin
        if (md_en) state_d = MD_INIT;
      end
      MD_INIT: begin
        imd.we     = 2'b11;
        imd.d1     = {2'b00, div_en_i ? op_a_i : op_b_i};
        // Divisor passes the adder unchanged for the zero check
        div_zero_d = adder.is_equal;
        count_d    = 5'd31;
        state_d    = MD_RUN;
      end
      MD_RUN: begin
        imd.we = 2'b11;
        if (div_en_i) begin
          imd.d0 = {2'b00, sub_ok ? adder.adder_result : rem_shift[31:0]};
          imd.d1 = {2'b00, shreg[30:0], sub_ok};
        end else begin
          imd.d0 = {2'b00, adder.adder_ext[33:2]};
          imd.d1 = {2'b00, adder.adder_ext[1], shreg[31:1]};
        end
        count_d = count_q - 5'd1;
        if (count_q == 5'd0) state_d = MD_FIX;
      end
      MD_FIX: begin
        // x/0 gives all ones, x%0 gives x
        if (div_en_i && div_zero_q) begin
          imd.we = 2'b11;
          imd.d0 = {2'b00, op_a_i};
          imd.d1 = {2'b00, {32{1'b1}}};
        end
        state_d = MD_DONE;
      end
      MD_DONE: begin
        valid_o = 1'b1;
        state_d = MD_IDLE;
      end
      default: state_d = MD_IDLE;
    endcase
    // Enable dropped mid-operation aborts
    if (!md_en) state_d = MD_IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= MD_IDLE;
      count_q    <= '0;
      div_zero_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      count_q    <= count_d;
      div_zero_q <= div_zero_d;
    end
  end

  assign result_o = (operator_i == MD_OP_MUL || operator_i == MD_OP_DIVU) ? shreg : acc;

  // Issue controller never enables both units at once
  assert property (@(posedge clk_i) disable iff (reset_i) !(mult_en_i && div_en_i))
    else $error("ex_multdiv: mult_en and div_en both high");

endmodule

`default_nettype wire

// File: ex_block.sv
/*
 * Execution block: ALU plus optional slow multdiv, result and
 * intermediate write muxing, valid generation
 */
`default_nettype none

module ex_block import ex_pkg::*; #(
  parameter rv32m_e RV32M = RV32MSlow
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  alu_op_e alu_operator_i,
  input  word_t   alu_operand_a_i,
  input  word_t   alu_operand_b_i,
  input  md_op_e  md_operator_i,
  input  logic    mult_en_i,
  input  logic    div_en_i,
  input  logic    md_sel_i,
  input  word_t   md_operand_a_i,
  input  word_t   md_operand_b_i,
  ex_imd_if.ex    imd,
  output word_t   result_o,
  output logic    branch_decision_o,
  output logic    ex_valid_o
);

  word_t      alu_result;
  word_t      md_result;
  logic       md_valid;

  ex_adder_if adder_bus ();
  ex_imd_if   md_imd ();

  // The ALU never writes the intermediate registers
  assign md_imd.q0 = imd.q0;
  assign md_imd.q1 = imd.q1;
  assign imd.we    = md_sel_i ? md_imd.we : 2'b00;
  assign imd.d0    = md_sel_i ? md_imd.d0 : '0;
  assign imd.d1    = md_sel_i ? md_imd.d1 : '0;

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .multdiv_sel_i(md_sel_i),
    .adder        (adder_bus.alu),
    .result_o     (alu_result),
    .comparison_o (branch_decision_o)
  );

  if (RV32M == RV32MSlow) begin : gen_md_slow
    ex_multdiv multdiv_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .mult_en_i (mult_en_i),
      .div_en_i  (div_en_i),
      .operator_i(md_operator_i),
      .op_a_i    (md_operand_a_i),
      .op_b_i    (md_operand_b_i),
      .adder     (adder_bus.md),
      .imd       (md_imd.ex),
      .valid_o   (md_valid),
      .result_o  (md_result)
    );
  end else begin : gen_md_none
    // Multdiv ops finish at once with zero
    assign adder_bus.operand_a = '0;
    assign adder_bus.operand_b = '0;
    assign md_imd.we           = 2'b00;
    assign md_imd.d0           = '0;
    assign md_imd.d1           = '0;
    assign md_valid            = 1'b1;
    assign md_result           = '0;
  end

  // ALU ops complete in the cycle they are presented
  assign result_o   = md_sel_i ? md_result : alu_result;
  assign ex_valid_o = md_sel_i ? md_valid : 1'b1;

endmodule

`default_nettype wire

// File: ex_issue_ctrl.sv
/*
 * Issue control: request handshake, held operation and operands,
 * intermediate value registers and result return
 */
`default_nettype none

module ex_issue_ctrl import ex_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  logic    req_md_i,
  input  alu_op_e req_alu_op_i,
  input  md_op_e  req_md_op_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output alu_op_e alu_op_o,
  output md_op_e  md_op_o,
  output word_t   op_a_o,
  output word_t   op_b_o,
  output logic    mult_en_o,
  output logic    div_en_o,
  output logic    md_sel_o,
  ex_imd_if.regs  imd,
  input  logic    ex_valid_i,
  input  word_t   block_result_i,
  input  logic    block_branch_i,
  output word_t   result_o,
  output logic    branch_o,
  output logic    result_valid_o
);

  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_BUSY,
    ISS_RESP
  } iss_state_e;

  iss_state_e state_q;
  logic       accept;
  logic       done;

  assign req_ready_o    = (state_q == ISS_IDLE);
  assign accept         = req_valid_i & req_ready_o;
  assign done           = (state_q == ISS_BUSY) & ex_valid_i;
  assign result_valid_o = (state_q == ISS_RESP);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= ISS_IDLE;
      alu_op_o <= ALU_ADD;
      md_op_o  <= MD_OP_MUL;
      md_sel_o <= 1'b0;
    end else begin
      case (state_q)
        ISS_IDLE: begin
          if (accept) begin
            state_q  <= ISS_BUSY;
            alu_op_o <= req_alu_op_i;
            md_op_o  <= req_md_op_i;
            md_sel_o <= req_md_i;
          end
        end
        ISS_BUSY: if (ex_valid_i) state_q <= ISS_RESP;
        default:  state_q <= ISS_IDLE;
      endcase
    end
  end

  // Operands and result
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_a_o <= operand_a_i;
      op_b_o <= operand_b_i;
    end
    if (done) begin
      result_o <= block_result_i;
      branch_o <= block_branch_i;
    end
  end

  // Enables held only until the block reports valid
  assign mult_en_o = (state_q == ISS_BUSY) & md_sel_o &
                     (md_op_o == MD_OP_MUL || md_op_o == MD_OP_MULHU);
  assign div_en_o  = (state_q == ISS_BUSY) & md_sel_o &
                     (md_op_o == MD_OP_DIVU || md_op_o == MD_OP_REMU);

  // Intermediate value registers
  always_ff @(posedge clk_i) begin
    if (imd.we[0]) imd.q0 <= imd.d0;
    if (imd.we[1]) imd.q1 <= imd.d1;
  end

  // Block writes the intermediate registers only while an operation is in flight
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (state_q != ISS_BUSY) |-> (imd.we == 2'b00))
    else $error("ex_issue_ctrl: intermediate write outside a busy operation");

endmodule

`default_nettype wire

// File: ex_unit.sv
/*
 * Execution stage top: issue controller and execution block
 */
`default_nettype none

module ex_unit import ex_pkg::*; #(
  parameter rv32m_e RV32M = RV32MSlow
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  logic    req_md_i,
  input  alu_op_e req_alu_op_i,
  input  md_op_e  req_md_op_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    branch_o,
  output logic    result_valid_o
);

  alu_op_e alu_op;
  md_op_e  md_op;
  word_t   op_a;
  word_t   op_b;
  logic    mult_en;
  logic    div_en;
  logic    md_sel;
  logic    ex_valid;
  word_t   block_result;
  logic    block_branch;

  ex_imd_if imd_bus ();

  ex_issue_ctrl issue_ctrl_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_md_i      (req_md_i),
    .req_alu_op_i  (req_alu_op_i),
    .req_md_op_i   (req_md_op_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .alu_op_o      (alu_op),
    .md_op_o       (md_op),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .mult_en_o     (mult_en),
    .div_en_o      (div_en),
    .md_sel_o      (md_sel),
    .imd           (imd_bus.regs),
    .ex_valid_i    (ex_valid),
    .block_result_i(block_result),
    .block_branch_i(block_branch),
    .result_o      (result_o),
    .branch_o      (branch_o),
    .result_valid_o(result_valid_o)
  );

  ex_block #(
    .RV32M(RV32M)
  ) ex_block_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .alu_operator_i   (alu_op),
    .alu_operand_a_i  (op_a),
    .alu_operand_b_i  (op_b),
    .md_operator_i    (md_op),
    .mult_en_i        (mult_en),
    .div_en_i         (div_en),
    .md_sel_i         (md_sel),
    .md_operand_a_i   (op_a),
    .md_operand_b_i   (op_b),
    .imd              (imd_bus.ex),
    .result_o         (block_result),
    .branch_decision_o(block_branch),
    .ex_valid_o       (ex_valid)
  );

endmodule

`default_nettype wire

// File: tb_ex_unit.sv
/*
 * Testbench for the execution stage: xorshift stimulus, reference model,
 * compare tasks, handshake checks and a watchdog
 */
`default_nettype none

module tb_ex_unit import ex_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int ALU_PAIRS  = 200;
  localparam int BR_PAIRS   = 50;
  localparam int MD_PAIRS   = 100;
  localparam int NUM_EDGE   = 6;
  localparam int NUM_REQ    = ALU_PAIRS * 10 + (NUM_EDGE * NUM_EDGE + BR_PAIRS) * 6 +
                              2 * MD_PAIRS + 2 * (MD_PAIRS + NUM_EDGE * NUM_EDGE);
  // Each request gets 40 cycles, plus room for reset
  localparam int WATCHDOG_CYCLES = 40 * NUM_REQ + 100;

  localparam alu_op_e ARITH_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                                         ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
  localparam alu_op_e BRANCH_OPS [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  // Sign and unsigned boundaries
  localparam word_t EDGE_VALUES [NUM_EDGE] = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                                               32'h8000_0000, 32'h8000_0001, 32'hffff_ffff};

  logic    clk_i;
  logic    reset_i;
  logic    req_valid_i;
  logic    req_ready_o;
  logic    req_md_i;
  alu_op_e req_alu_op_i;
  md_op_e  req_md_op_i;
  word_t   operand_a_i;
  word_t   operand_b_i;
  word_t   result_o;
  logic    branch_o;
  logic    result_valid_o;
  word_t   rng_state;

  ex_unit #(
    .RV32M(RV32MSlow)
  ) UUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_md_i      (req_md_i),
    .req_alu_op_i  (req_alu_op_i),
    .req_md_op_i   (req_md_op_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .result_o      (result_o),
    .branch_o      (branch_o),
    .result_valid_o(result_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    stop_with_failure("Watchdog expired, a request never completed");
  end

  ///////////////////////////////
  // Reporting and compares
  ///////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_word(input string test, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error %s expected %08h actual %08h", test, expected, actual));
    end
  endtask

  task automatic check_branch(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error %s expected %0b actual %0b", test, expected, actual));
    end
  endtask

  ///////////////////////////////
  // Stimulus and model
  ///////////////////////////////

  function automatic word_t xorshift32(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Mostly random, with zero, all ones, sign bit and small values mixed in
  function automatic word_t pick_operand();
    word_t sel;
    word_t v;
    sel = next_random();
    case (sel[2:0])
      3'd0:    v = '0;
      3'd1:    v = '1;
      3'd2:    v = 32'h8000_0000;
      3'd3:    v = next_random() & 32'h0000_00ff;
      default: v = next_random();
    endcase
    return v;
  endfunction

  function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_XOR:  r = a ^ b;
      ALU_OR:   r = a | b;
      ALU_AND:  r = a & b;
      ALU_SLL:  r = a << b[4:0];
      ALU_SRL:  r = a >> b[4:0];
      ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  r = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: r = {31'b0, a < b};
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic model_branch(input alu_op_e op, input word_t a, input word_t b);
    logic taken;
    case (op)
      ALU_EQ:  taken = (a == b);
      ALU_NE:  taken = (a != b);
      ALU_LT:  taken = ($signed(a) < $signed(b));
      ALU_GE:  taken = ($signed(a) >= $signed(b));
      ALU_LTU: taken = (a < b);
      default: taken = (a >= b);
    endcase
    return taken;
  endfunction

  function automatic word_t model_md(input md_op_e op, input word_t a, input word_t b);
    logic [63:0] prod;
    word_t       r;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      MD_OP_MUL:   r = prod[31:0];
      MD_OP_MULHU: r = prod[63:32];
      // Divide by zero gives an all ones quotient and the dividend as remainder
      MD_OP_DIVU:  r = (b == '0) ? '1 : a / b;
      default:     r = (b == '0) ? a : a % b;
    endcase
    return r;
  endfunction

  ///////////////////////////////
  // Request sequencing
  ///////////////////////////////

  // Entered and left 1 ns after a rising edge, with the unit idle
  task automatic run_request(input logic md, input alu_op_e aop, input md_op_e mop,
                             input word_t a, input word_t b,
                             output word_t res, output logic br, output int cycles);
    if (req_ready_o !== 1'b1) stop_with_failure("req_ready_o low while the unit was idle");
    req_valid_i  = 1'b1;
    req_md_i     = md;
    req_alu_op_i = aop;
    req_md_op_i  = mop;
    operand_a_i  = a;
    operand_b_i  = b;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    cycles      = 1;
    while (result_valid_o !== 1'b1) begin
      if (req_ready_o !== 1'b0) stop_with_failure("req_ready_o high before the result pulse");
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (req_ready_o !== 1'b0) stop_with_failure("req_ready_o high during the result pulse");
    res = result_o;
    br  = branch_o;
    @(posedge clk_i);
    #1;
    if (result_valid_o !== 1'b0) stop_with_failure("Result pulse lasted more than one cycle");
    if (req_ready_o !== 1'b1) stop_with_failure("req_ready_o stayed low after the result pulse");
  endtask

  task automatic test_alu(input alu_op_e op, input word_t a, input word_t b);
    word_t res;
    logic  br;
    int    cycles;
    string name;
    name = $sformatf("%s a=%08h b=%08h", op.name(), a, b);
    run_request(1'b0, op, MD_OP_MUL, a, b, res, br, cycles);
    if (cycles != 2) begin
      stop_with_failure($sformatf("error %s latency expected 2 actual %0d", name, cycles));
    end
    check_word(name, model_alu(op, a, b), res);
  endtask

  task automatic test_branch(input alu_op_e op, input word_t a, input word_t b);
    word_t res;
    logic  br;
    int    cycles;
    string name;
    name = $sformatf("%s a=%08h b=%08h", op.name(), a, b);
    run_request(1'b0, op, MD_OP_MUL, a, b, res, br, cycles);
    if (cycles != 2) begin
      stop_with_failure($sformatf("error %s latency expected 2 actual %0d", name, cycles));
    end
    check_branch(name, model_branch(op, a, b), br);
  endtask

  task automatic test_md(input md_op_e op, input word_t a, input word_t b);
    word_t res;
    logic  br;
    int    cycles;
    run_request(1'b1, ALU_ADD, op, a, b, res, br, cycles);
    check_word($sformatf("%s a=%08h b=%08h", op.name(), a, b), model_md(op, a, b), res);
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    word_t a;
    word_t b;
    rng_state    = 32'd13;
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_md_i     = 1'b0;
    req_alu_op_i = ALU_ADD;
    req_md_op_i  = MD_OP_MUL;
    operand_a_i  = '0;
    operand_b_i  = '0;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Idle straight out of reset
    if (req_ready_o !== 1'b1) stop_with_failure("req_ready_o low after reset");
    if (result_valid_o !== 1'b0) stop_with_failure("result_valid_o high after reset");

    for (int i = 0; i < ALU_PAIRS; i++) begin
      a = pick_operand();
      b = pick_operand();
      for (int k = 0; k < 10; k++) begin
        test_alu(ARITH_OPS[k], a, b);
      end
    end

    // Branch compares over all boundary pairs, then random pairs
    for (int i = 0; i < NUM_EDGE; i++) begin
      for (int j = 0; j < NUM_EDGE; j++) begin
        for (int k = 0; k < 6; k++) begin
          test_branch(BRANCH_OPS[k], EDGE_VALUES[i], EDGE_VALUES[j]);
        end
      end
    end
    for (int i = 0; i < BR_PAIRS; i++) begin
      a = pick_operand();
      b = pick_operand();
      for (int k = 0; k < 6; k++) begin
        test_branch(BRANCH_OPS[k], a, b);
      end
    end

    for (int i = 0; i < MD_PAIRS; i++) begin
      a = pick_operand();
      b = pick_operand();
      test_md(MD_OP_MUL, a, b);
      test_md(MD_OP_MULHU, a, b);
    end

    // Zero divisors come from both the edge list and the random mix
    for (int i = 0; i < NUM_EDGE; i++) begin
      for (int j = 0; j < NUM_EDGE; j++) begin
        test_md(MD_OP_DIVU, EDGE_VALUES[i], EDGE_VALUES[j]);
        test_md(MD_OP_REMU, EDGE_VALUES[i], EDGE_VALUES[j]);
      end
    end
    for (int i = 0; i < MD_PAIRS; i++) begin
      a = pick_operand();
      b = pick_operand();
      test_md(MD_OP_DIVU, a, b);
      test_md(MD_OP_REMU, a, b);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: ex_unit.f
ex_pkg.sv
ex_if.sv
ex_alu.sv
ex_multdiv.sv
ex_block.sv
ex_issue_ctrl.sv
ex_unit.sv
tb_ex_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ex_unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ex_unit.f --top-module tb_ex_unit \
  -Mdir obj_dir -o tb_ex_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_ex_unit 2>&1)
status=$?
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
